//--- test/store_cases.txt
# s funct3 base offset data | l addr exp_mask exp_data | g responses | f
# all fields hex, offset is the 12-bit immediate
s 0 00001000 000 a1a2a3a4
s 0 00001000 001 b1b2b3b4
s 0 00001004 ffe c1c2c3c4
s 0 00000ffc 007 d1d2d3d4
s 1 00001010 000 00005566
s 1 00001010 002 00007788
s 2 00001020 ffc 11223344
l 00001001 f d4c4b4a4
l 00001010 f 77885566
g 7
s 2 00002000 000 11111111
s 1 00002000 002 2222abcd
s 0 00002001 000 000000ee
l 00002000 f abcdee11
s 0 00002003 000 00000077
l 00002002 f 77cdee11
s 1 00003000 002 0000beef
l 00003000 c beef0000
s 2 00004000 000 cafef00d
s 0 00004000 005 00000099
s 1 00004000 006 00001234
g 1
l 00002000 e 77cdee00
f
l 00002000 0 00000000
s 2 00005000 010 89abcdef
l 00005010 f 89abcdef
g 2

//--- vlog.f
hw/store_pkg.sv
hw/store_req_if.sv
hw/store_agu.sv
hw/store_buffer.sv
hw/dmem_write_ctrl.sv
hw/load_forward.sv
hw/store_unit_top.sv
test/store_unit_assertions.sv
test/tb_store_unit.sv

//--- run.sh
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_store_unit -f vlog.f \
    -o sim_store_unit && ./obj_dir/sim_store_unit +verilator+error+limit+100 > sim.log 2>&1
grep -q "^No errors$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- test/tb_store_unit.sv
`timescale 1ns/100ps
`default_nettype none

module tb_store_unit
    import store_pkg::*;
();

    localparam int ENTRIES    = 2**DEFAULT_SB_DEPTH_LOG2;
    localparam int WAIT_LIMIT = 100;

    logic         clk = 1'b0;
    logic         reset;
    logic         flush;
    logic         store_valid;
    store_width_t store_funct3;
    addr_t        store_base;
    imm_t         store_offset;
    word_t        store_data;
    logic         store_full;
    logic         dmem_write;
    addr_t        dmem_addr;
    mask_t        dmem_wmask;
    word_t        dmem_wdata;
    logic         dmem_resp;
    logic         load_valid;
    addr_t        load_addr;
    mask_t        fwd_mask;
    word_t        fwd_data;

    // {word address, mask, lane data} of every store not yet written
    logic [67:0] model_q [$];
    // stores still held in the buffer
    int          held;
    // write that outlived a flush and is still on the memory port
    logic        orphan;
    integer      seed = 89872;

    store_unit_top #(.SB_DEPTH_LOG2(DEFAULT_SB_DEPTH_LOG2)) u_store_unit_top (.*);

    always #5 clk = ~clk;

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
        $display("Errors found");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic abort_run(input string what);
        $display("%0t %s", $time, what);
        $display("Errors found");
        $fatal(1, "%s", what);
    endtask

    // size in bytes is 1 << funct3
    // byte j of the data lands in lane addr[1:0] + j
    function automatic logic [67:0] aligned_store(input logic [2:0] funct3, input addr_t base,
                                                  input imm_t offset, input word_t data);
        addr_t ea;
        mask_t mask;
        word_t lanes;
        int    lane;
        ea    = base + addr_t'(int'(offset));
        mask  = '0;
        lanes = '0;
        for (int j = 0; j < (1 << funct3); j++) begin
            lane               = int'(ea[1:0]) + j;
            mask[lane]         = 1'b1;
            lanes[8*lane +: 8] = data[8*j +: 8];
        end
        return {ea[31:2], 2'b00, mask, lanes};
    endfunction

    task automatic issue_store(input logic [2:0] funct3, input addr_t base, input imm_t offset,
                               input word_t data);
        assert (!store_full) else abort_run("store issued while the buffer is full");
        store_valid  = 1'b1;
        store_funct3 = store_width_t'(funct3);
        store_base   = base;
        store_offset = offset;
        store_data   = data;
        step();
        store_valid = 1'b0;
        step();
        model_q.push_back(aligned_store(funct3, base, offset, data));
        held++;
    endtask

    task automatic check_load(input addr_t addr, input mask_t exp_mask, input word_t exp_data);
        load_valid = 1'b1;
        load_addr  = addr;
        #2;
        assert (fwd_mask == exp_mask)
            else report_mismatch("fwd_mask", 32'(exp_mask), 32'(fwd_mask));
        assert (fwd_data == exp_data) else report_mismatch("fwd_data", exp_data, fwd_data);
        load_valid = 1'b0;
        step();
    endtask

    task automatic grant_writes(input int count);
        logic [67:0] exp;
        int          waited;
        int          delay;
        for (int k = 0; k < count; k++) begin
            waited = 0;
            while (!dmem_write) begin
                assert (waited < WAIT_LIMIT) else abort_run("timeout waiting for dmem_write");
                step();
                waited++;
            end
            assert (model_q.size() > 0) else abort_run("memory write with no store pending");
            // memory takes a few cycles before it answers
            delay = $random(seed) & 3;
            repeat (delay) step();
            exp = model_q.pop_front();
            assert (dmem_addr == exp[67:36]) else report_mismatch("dmem_addr", exp[67:36], dmem_addr);
            assert (dmem_wmask == exp[35:32])
                else report_mismatch("dmem_wmask", 32'(exp[35:32]), 32'(dmem_wmask));
            assert (dmem_wdata == exp[31:0]) else report_mismatch("dmem_wdata", exp[31:0], dmem_wdata);
            dmem_resp = 1'b1;
            step();
            dmem_resp = 1'b0;
            if (orphan) begin
                orphan = 1'b0;
            end else begin
                held--;
            end
        end
    endtask

    task automatic flush_buffer();
        flush = 1'b1;
        step();
        flush = 1'b0;
        // the oldest store is already on the port and completes
        if (model_q.size() > 0) begin
            orphan = 1'b1;
        end
        while (model_q.size() > 1) begin
            void'(model_q.pop_back());
        end
        held = 0;
    endtask

    initial begin
        int          fd;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
        reset        = 1'b1;
        flush        = 1'b0;
        store_valid  = 1'b0;
        store_funct3 = STORE_SB;
        store_base   = '0;
        store_offset = '0;
        store_data   = '0;
        dmem_resp    = 1'b0;
        load_valid   = 1'b0;
        load_addr    = '0;
        held         = 0;
        orphan       = 1'b0;
        fd = $fopen("test/store_cases.txt", "r");
        assert (fd != 0) else abort_run("cannot open test/store_cases.txt");
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
        step();
        while ($fgets(line, fd) != 0) begin
            op = line.getc(0);
            if (op == "#" || op == "\n") begin
                continue;
            end
            assert (store_full == (held == ENTRIES))
                else report_mismatch("store_full", 32'(held == ENTRIES), 32'(store_full));
            void'($sscanf(line.substr(1, line.len() - 1), "%h %h %h %h", a, b, c, d));
            case (op)
                "s": issue_store(a[2:0], b, c[11:0], d);
                "l": check_load(a, b[3:0], c);
                "g": grant_writes(int'(a));
                "f": flush_buffer();
                default: abort_run("unknown operation in the cases file");
            endcase
        end
        $fclose(fd);
        assert (model_q.size() == 0) else abort_run("stores never reached the memory port");
        // drained buffer leaves the write port idle
        step();
        assert (!dmem_write) else report_mismatch("dmem_write", 32'(0), 32'(dmem_write));
        assert (store_full == (held == ENTRIES))
            else report_mismatch("store_full", 32'(held == ENTRIES), 32'(store_full));
        if (u_store_unit_top.u_assertions.fail_count == 0) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Errors found");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule

`default_nettype wire

//--- test/store_unit_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module store_unit_assertions
    import store_pkg::*;
(
    input logic  clk,
    input logic  reset,
    input logic  store_valid,
    input logic  store_full,
    input logic  dmem_write,
    input logic  dmem_resp,
    input addr_t dmem_addr,
    input mask_t dmem_wmask,
    input word_t dmem_wdata
);

    int fail_count = 0;

    no_store_when_full: assert property (@(posedge clk) disable iff (reset)
        !(store_valid && store_full)) else begin
        $error("store_valid high while store_full is high");
        fail_count++;
    end

    // request held until memory answers
    write_held_stable: assert property (@(posedge clk) disable iff (reset)
        dmem_write && !dmem_resp |=> dmem_write && $stable(dmem_addr)
            && $stable(dmem_wmask) && $stable(dmem_wdata)) else begin
        $error("memory write request changed before the response");
        fail_count++;
    end

    quiet_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !dmem_write && !store_full) else begin
        $error("dmem_write or store_full high right after reset");
        fail_count++;
    end

endmodule

bind store_unit_top store_unit_assertions u_assertions (.*);

`default_nettype wire

//--- hw/store_unit_top.sv
`timescale 1ns/100ps
`default_nettype none

module store_unit_top
    import store_pkg::*;
#(
    parameter int SB_DEPTH_LOG2 = DEFAULT_SB_DEPTH_LOG2
) (
    input  logic         clk,
    input  logic         reset,
    input  logic         flush,

    // issue side
    input  logic         store_valid,
    input  store_width_t store_funct3,
    input  addr_t        store_base,
    input  imm_t         store_offset,
    input  word_t        store_data,
    output logic         store_full,

    // data memory write port
    output logic         dmem_write,
    output addr_t        dmem_addr,
    output mask_t        dmem_wmask,
    output word_t        dmem_wdata,
    input  logic         dmem_resp,

    // load lookup
    input  logic         load_valid,
    input  addr_t        load_addr,
    output mask_t        fwd_mask,
    output word_t        fwd_data
);

    localparam int SB_ENTRIES = 2**SB_DEPTH_LOG2;

    store_req_if agu_st ();
    store_req_if sb_oldest ();

    logic  pop;
    logic  snap_valid [SB_ENTRIES];
    addr_t snap_addr  [SB_ENTRIES];
    mask_t snap_wmask [SB_ENTRIES];
    word_t snap_wdata [SB_ENTRIES];

    store_agu u_store_agu (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .store_valid  (store_valid),
        .store_funct3 (store_funct3),
        .store_base   (store_base),
        .store_offset (store_offset),
        .store_data   (store_data),
        .st           (agu_st.src)
    );

    store_buffer #(
        .SB_DEPTH_LOG2 (SB_DEPTH_LOG2)
    ) u_store_buffer (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .wr         (agu_st.dst),
        .oldest     (sb_oldest.src),
        .pop        (pop),
        .full       (store_full),
        .snap_valid (snap_valid),
        .snap_addr  (snap_addr),
        .snap_wmask (snap_wmask),
        .snap_wdata (snap_wdata)
    );

    dmem_write_ctrl u_dmem_write_ctrl (
        .clk        (clk),
        .reset      (reset),
        .oldest     (sb_oldest.dst),
        .dmem_write (dmem_write),
        .dmem_addr  (dmem_addr),
        .dmem_wmask (dmem_wmask),
        .dmem_wdata (dmem_wdata),
        .dmem_resp  (dmem_resp),
        .pop        (pop)
    );

    load_forward #(
        .SB_DEPTH_LOG2 (SB_DEPTH_LOG2)
    ) u_load_forward (
        .load_valid (load_valid),
        .load_addr  (load_addr),
        .snap_valid (snap_valid),
        .snap_addr  (snap_addr),
        .snap_wmask (snap_wmask),
        .snap_wdata (snap_wdata),
        .fwd_mask   (fwd_mask),
        .fwd_data   (fwd_data)
    );

endmodule

`default_nettype wire

//--- hw/load_forward.sv
`timescale 1ns/100ps
`default_nettype none

module load_forward
    import store_pkg::*;
#(
    parameter int SB_DEPTH_LOG2 = DEFAULT_SB_DEPTH_LOG2
) (
    input  logic  load_valid,
    input  addr_t load_addr,
    input  logic  snap_valid [2**SB_DEPTH_LOG2],
    input  addr_t snap_addr  [2**SB_DEPTH_LOG2],
    input  mask_t snap_wmask [2**SB_DEPTH_LOG2],
    input  word_t snap_wdata [2**SB_DEPTH_LOG2],
    output mask_t fwd_mask,
    output word_t fwd_data
);

    localparam int SB_ENTRIES = 2**SB_DEPTH_LOG2;

    logic word_hit [SB_ENTRIES];

    always_comb begin
        for (int i = 0; i < SB_ENTRIES; i++) begin
            word_hit[i] = snap_valid[i] && (snap_addr[i][31:2] == load_addr[31:2]);
        end
    end

    // oldest first, so the youngest covering store wins each lane
    always_comb begin
        fwd_mask = '0;
        fwd_data = '0;
        if (load_valid) begin
            for (int lane = 0; lane < 4; lane++) begin
                for (int i = SB_ENTRIES - 1; i >= 0; i--) begin
                    if (word_hit[i] && snap_wmask[i][lane]) begin
                        fwd_mask[lane]          = 1'b1;
                        fwd_data[8*lane +: 8]   = snap_wdata[i][8*lane +: 8];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/dmem_write_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module dmem_write_ctrl
    import store_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    store_req_if.dst oldest,
    output logic     dmem_write,
    output addr_t    dmem_addr,
    output mask_t    dmem_wmask,
    output word_t    dmem_wdata,
    input  logic     dmem_resp,
    output logic     pop
);

    typedef enum logic {
        ST_IDLE,
        ST_BUSY
    } state_t;

    state_t state;

    addr_t req_addr;
    mask_t req_wmask;
    word_t req_wdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (oldest.valid) begin
                        state <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    if (dmem_resp) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request held stable until the response
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && oldest.valid) begin
            req_addr  <= oldest.addr;
            req_wmask <= oldest.wmask;
            req_wdata <= oldest.wdata;
        end
    end

    assign dmem_write = (state == ST_BUSY);
    assign dmem_addr  = req_addr;
    assign dmem_wmask = req_wmask;
    assign dmem_wdata = req_wdata;
    assign pop        = (state == ST_BUSY) && dmem_resp;

endmodule

`default_nettype wire

//--- hw/store_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module store_buffer
    import store_pkg::*;
#(
    parameter int SB_DEPTH_LOG2 = DEFAULT_SB_DEPTH_LOG2
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     flush,
    store_req_if.dst wr,
    store_req_if.src oldest,
    input  logic     pop,
    output logic     full,
    output logic     snap_valid [2**SB_DEPTH_LOG2],
    output addr_t    snap_addr  [2**SB_DEPTH_LOG2],
    output mask_t    snap_wmask [2**SB_DEPTH_LOG2],
    output word_t    snap_wdata [2**SB_DEPTH_LOG2]
);

    localparam int SB_ENTRIES = 2**SB_DEPTH_LOG2;

    typedef logic [SB_DEPTH_LOG2-1:0] ptr_t;

    logic  valid_arr [SB_ENTRIES];
    addr_t addr_arr  [SB_ENTRIES];
    mask_t wmask_arr [SB_ENTRIES];
    word_t wdata_arr [SB_ENTRIES];

    // head is the next free slot, tail the oldest entry
    ptr_t head;
    ptr_t tail;

    // mirror of the write controller, so that the pop of a write
    // that outlived a flush does not remove a newer entry
    logic in_flight;
    logic in_flight_next;
    logic drop_pop;
    logic do_pop;

    assign in_flight_next = in_flight ? !pop : valid_arr[tail];
    assign do_pop         = pop && !drop_pop;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 1'b0;
            drop_pop  <= 1'b0;
        end else begin
            in_flight <= in_flight_next;
            if (flush) begin
                drop_pop <= in_flight_next;
            end else if (pop) begin
                drop_pop <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head <= '0;
            tail <= '0;
            for (int i = 0; i < SB_ENTRIES; i++) begin
                valid_arr[i] <= 1'b0;
            end
        end else begin
            if (do_pop && valid_arr[tail]) begin
                valid_arr[tail] <= 1'b0;
                tail            <= tail + 1'b1;
            end
            if (wr.valid) begin
                valid_arr[head] <= 1'b1;
                head            <= head + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr.valid) begin
            addr_arr[head]  <= wr.addr;
            wmask_arr[head] <= wr.wmask;
            wdata_arr[head] <= wr.wdata;
        end
    end

    always_comb begin
        full = 1'b1;
        for (int i = 0; i < SB_ENTRIES; i++) begin
            if (!valid_arr[i]) begin
                full = 1'b0;
            end
        end
    end

    assign oldest.valid = valid_arr[tail];
    assign oldest.addr  = addr_arr[tail];
    assign oldest.wmask = wmask_arr[tail];
    assign oldest.wdata = wdata_arr[tail];

    // index 0 is the newest entry, just behind head
    always_comb begin
        for (int i = 0; i < SB_ENTRIES; i++) begin
            snap_valid[i] = valid_arr[ptr_t'(head - 1 - i)];
            snap_addr[i]  = addr_arr[ptr_t'(head - 1 - i)];
            snap_wmask[i] = wmask_arr[ptr_t'(head - 1 - i)];
            snap_wdata[i] = wdata_arr[ptr_t'(head - 1 - i)];
        end
    end

endmodule

`default_nettype wire

//--- hw/store_agu.sv
`timescale 1ns/100ps
`default_nettype none

module store_agu
    import store_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         flush,
    input  logic         store_valid,
    input  store_width_t store_funct3,
    input  addr_t        store_base,
    input  imm_t         store_offset,
    input  word_t        store_data,
    store_req_if.src     st
);

    addr_t eff_addr;
    mask_t base_mask;
    mask_t lane_mask;
    word_t rep_data;
    word_t lane_data;

    always_comb begin
        eff_addr = store_base + {{20{store_offset[11]}}, store_offset};

        case (store_funct3)
            STORE_SB: begin
                base_mask = 4'b0001;
                rep_data  = {4{store_data[7:0]}};
            end
            STORE_SH: begin
                base_mask = 4'b0011;
                rep_data  = {2{store_data[15:0]}};
            end
            STORE_SW: begin
                base_mask = 4'b1111;
                rep_data  = store_data;
            end
            default: begin
                base_mask = 4'b0000;
                rep_data  = '0;
            end
        endcase

        // low address bits select the lanes
        lane_mask = base_mask << eff_addr[1:0];

        for (int b = 0; b < 4; b++) begin
            lane_data[8*b +: 8] = lane_mask[b] ? rep_data[8*b +: 8] : 8'h00;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            st.valid <= 1'b0;
        end else begin
            st.valid <= store_valid;
        end
    end

    always_ff @(posedge clk) begin
        st.addr  <= {eff_addr[31:2], 2'b00};
        st.wmask <= lane_mask;
        st.wdata <= lane_data;
    end

endmodule

`default_nettype wire

//--- hw/store_req_if.sv
`timescale 1ns/100ps
`default_nettype none

interface store_req_if
    import store_pkg::*;
();

    logic  valid;
    // always word aligned
    addr_t addr;
    mask_t wmask;
    // bytes sit in their final lanes
    word_t wdata;

    modport src (
        output valid,
        output addr,
        output wmask,
        output wdata
    );

    modport dst (
        input valid,
        input addr,
        input wmask,
        input wdata
    );

endinterface

`default_nettype wire

//--- hw/store_pkg.sv
`default_nettype none

package store_pkg;

    // data and address widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;

    // one bit per byte lane
    typedef logic [3:0] mask_t;

    // s-type immediate
    typedef logic signed [11:0] imm_t;

    // funct3 of the rv32i store opcode
    typedef enum logic [2:0] {
        STORE_SB = 3'b000,
        STORE_SH = 3'b001,
        STORE_SW = 3'b010
    } store_width_t;

    // 8 buffer entries unless the top level says otherwise
    localparam int DEFAULT_SB_DEPTH_LOG2 = 3;

endpackage

`default_nettype wire
